/* compile.f */
common/vec_pkg.sv
common/lane_issue_if.sv
lane/vec_lane.sv
dispatcher/vec_dispatcher.sv
src/vec_collector.sv
src/vec_unit.sv
tb/vec_unit_asserts.sv
tb/vec_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the vec_unit testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  --top-module vec_unit_tb \
  -Mdir "$build_dir" -o vec_unit_sim \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$build_dir/vec_unit_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Verification failed" "$log_file"; then
  exit 1
fi
exit 0

/* tb/vec_unit_tb.sv */
// Self-checking testbench for vec_unit, one instruction in flight at a time
// Expected values come from a shadow register file kept by ref_model
// Each wait loop gives up after Timeout cycles

`timescale 1ns/1ps

module vec_unit_tb;

  import vec_pkg::*;

  localparam int Timeout = 50;

  logic      clk_i;
  logic      reset_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  opcode_t   acc_req_op_i;
  vreg_idx_t acc_req_vd_i;
  vreg_idx_t acc_req_vs1_i;
  vreg_idx_t acc_req_vs2_i;
  elem_t     acc_req_scalar_i;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;
  elem_t     acc_resp_result_o;

  integer seed;
  elem_t  shadow [NrVRegs][VecLen];
  elem_t  exp_q [$];
  string  cur_test;
  int     checks;
  int     errors;
  int     test_checks;
  int     test_errors;
  int     nr_tests;

  // Response monitor state
  logic   in_flight;
  logic   resp_seen;
  int     lat;
  elem_t  exp_resp;

  vec_unit uut (
    .clk_i            (clk_i            ),
    .reset_i          (reset_i          ),
    .acc_req_valid_i  (acc_req_valid_i  ),
    .acc_req_ready_o  (acc_req_ready_o  ),
    .acc_req_op_i     (acc_req_op_i     ),
    .acc_req_vd_i     (acc_req_vd_i     ),
    .acc_req_vs1_i    (acc_req_vs1_i    ),
    .acc_req_vs2_i    (acc_req_vs2_i    ),
    .acc_req_scalar_i (acc_req_scalar_i ),
    .acc_resp_valid_o (acc_resp_valid_o ),
    .acc_resp_ready_i (acc_resp_ready_i ),
    .acc_resp_result_o(acc_resp_result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic elem_t ref_model(input opcode_t op, input vreg_idx_t vd,
                                      input vreg_idx_t vs1, input vreg_idx_t vs2,
                                      input elem_t scalar);
    elem_t res;
    elem_t a;
    elem_t b;
    res = '0;
    // Result comes from the old vs1
    if (op == OpRedSum) begin
      for (int i = 0; i < VecLen; i++) begin
        res = res + shadow[vs1][i];
      end
    end else if (op == OpExtract) begin
      res = shadow[vs1][elem_idx_t'(scalar)];
    end
    for (int i = 0; i < VecLen; i++) begin
      a = shadow[vs1][i];
      b = shadow[vs2][i];
      case (op)
        OpFillIdx: shadow[vd][i] = scalar + elem_t'(i);
        OpAdd:     shadow[vd][i] = a + b;
        OpSub:     shadow[vd][i] = a - b;
        OpAnd:     shadow[vd][i] = a & b;
        OpXor:     shadow[vd][i] = a ^ b;
        default:   ;
      endcase
    end
    return res;
  endfunction

  //////////////////////////////
  // Checks and report
  //////////////////////////////

  task automatic check_elem(input string name, input elem_t expected, input elem_t actual);
    checks++;
    test_checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    checks++;
    test_checks++;
    if (actual != expected) begin
      errors++;
      test_errors++;
      $display("FAIL %s latency: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    test_errors++;
    $display("ERROR in %s: %s", cur_test, msg);
  endtask

  task automatic timeout_abort(input string what);
    $display("ERROR in %s: timeout while waiting for %s", cur_test, what);
    $display("Verification failed");
    $finish;
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test;
    nr_tests++;
    $display("Test %s finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
  endtask

  // Checks every response as it appears, sampled mid-cycle
  always @(negedge clk_i) begin
    if (reset_i) begin
      in_flight = 1'b0;
      resp_seen = 1'b0;
      lat       = 0;
    end else begin
      if (in_flight) begin
        lat++;
        if (acc_resp_valid_o && !resp_seen) begin
          resp_seen = 1'b1;
          check_cycles(cur_test, 3, lat);
          if (exp_q.size() == 0) begin
            report_error("response arrived with no instruction outstanding");
          end else begin
            exp_resp = exp_q.pop_front();
            check_elem(cur_test, exp_resp, acc_resp_result_o);
          end
        end else if (acc_resp_valid_o) begin
          check_elem({cur_test, " hold"}, exp_resp, acc_resp_result_o);
        end else if (resp_seen) begin
          in_flight = 1'b0;
          resp_seen = 1'b0;
        end
      end
      if (acc_resp_valid_o && acc_req_ready_o) begin
        report_error("request ready is high while a response is pending");
      end
      // The next rising edge accepts this request
      if (acc_req_valid_i && acc_req_ready_o) begin
        if (in_flight) begin
          report_error("request accepted while an instruction was in flight");
        end
        in_flight = 1'b1;
        resp_seen = 1'b0;
        // Counts edges after the accepting one
        lat       = -1;
      end
    end
  end

  //////////////////////////////
  // Host side handshake
  //////////////////////////////

  task automatic put_req(input opcode_t op, input vreg_idx_t vd, input vreg_idx_t vs1,
                         input vreg_idx_t vs2, input elem_t scalar);
    exp_q.push_back(ref_model(op, vd, vs1, vs2, scalar));
    acc_req_valid_i  <= 1'b1;
    acc_req_op_i     <= op;
    acc_req_vd_i     <= vd;
    acc_req_vs1_i    <= vs1;
    acc_req_vs2_i    <= vs2;
    acc_req_scalar_i <= scalar;
  endtask

  task automatic drive_req(input opcode_t op, input vreg_idx_t vd, input vreg_idx_t vs1,
                           input vreg_idx_t vs2, input elem_t scalar);
    @(posedge clk_i);
    put_req(op, vd, vs1, vs2, scalar);
  endtask

  task automatic accept_req(input logic resp_ready);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!acc_req_ready_o) begin
      n++;
      if (n > Timeout) begin
        timeout_abort("request ready");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    acc_req_valid_i  <= 1'b0;
    acc_resp_ready_i <= resp_ready;
  endtask

  task automatic wait_resp;
    int n;
    n = 0;
    @(negedge clk_i);
    while (!acc_resp_valid_o) begin
      n++;
      if (n > Timeout) begin
        timeout_abort("response valid");
      end
      @(negedge clk_i);
    end
  endtask

  // Holds the response for hold cycles while a no-op waits behind it
  task automatic finish_req(input int hold);
    accept_req(hold == 0);
    wait_resp();
    for (int k = 1; k <= hold; k++) begin
      @(posedge clk_i);
      if (k == 1) begin
        put_req(opcode_t'(7), vreg_idx_t'($random(seed)), vreg_idx_t'($random(seed)),
                vreg_idx_t'($random(seed)), elem_t'($random(seed)));
      end
      if (k == hold) begin
        acc_resp_ready_i <= 1'b1;
      end
    end
    // Response taken on this edge
    @(posedge clk_i);
    if (hold > 0) begin
      accept_req(1'b1);
      wait_resp();
      @(posedge clk_i);
    end
  endtask

  task automatic send_req(input opcode_t op, input vreg_idx_t vd, input vreg_idx_t vs1,
                          input vreg_idx_t vs2, input elem_t scalar);
    drive_req(op, vd, vs1, vs2, scalar);
    finish_req(0);
  endtask

  // Extracts every element of every register
  task automatic check_regs;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < VecLen; i++) begin
        send_req(OpExtract, '0, vreg_idx_t'(r), '0, elem_t'(i));
      end
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int        hold;
    opcode_t   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    elem_t     fill;
    seed             = 32'hb4817ddf;
    checks           = 0;
    errors           = 0;
    nr_tests         = 0;
    cur_test         = "reset";
    reset_i          <= 1'b1;
    acc_req_valid_i  <= 1'b0;
    acc_req_op_i     <= OpFillIdx;
    acc_req_vd_i     <= '0;
    acc_req_vs1_i    <= '0;
    acc_req_vs2_i    <= '0;
    acc_req_scalar_i <= '0;
    acc_resp_ready_i <= 1'b1;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < VecLen; i++) begin
        shadow[r][i] = '0;
      end
    end
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    start_test("reset_state");
    @(negedge clk_i);
    if (acc_resp_valid_o !== 1'b0) begin
      report_error("response valid is high after reset");
    end
    if (acc_req_ready_o !== 1'b1) begin
      report_error("request ready is low after reset");
    end
    for (int r = 0; r < NrVRegs; r++) begin
      send_req(OpRedSum, '0, vreg_idx_t'(r), '0, '0);
    end
    end_test();

    start_test("fill_extract");
    for (int r = 0; r < NrVRegs; r++) begin
      send_req(OpFillIdx, vreg_idx_t'(r), '0, '0, elem_t'($random(seed)));
      for (int i = 0; i < VecLen; i++) begin
        // Upper scalar bits must not affect the index
        send_req(OpExtract, '0, vreg_idx_t'(r), '0,
                 (elem_t'($random(seed)) & 16'hfff8) | elem_t'(i));
      end
    end
    end_test();

    start_test("random_alu");
    for (int n = 0; n < 40; n++) begin
      op  = opcode_t'(1 + int'({$random(seed)} % 4));
      vd  = vreg_idx_t'($random(seed));
      vs1 = (n % 4 == 0) ? vd : vreg_idx_t'($random(seed));
      send_req(op, vd, vs1, vreg_idx_t'($random(seed)), elem_t'($random(seed)));
      send_req(OpRedSum, '0, vreg_idx_t'($random(seed)), '0, '0);
    end
    check_regs();
    end_test();

    start_test("wrap_and_zero");
    for (int r = 0; r < NrVRegs; r++) begin
      fill = 16'hff00 | (elem_t'($random(seed)) & 16'h00ff);
      send_req(OpFillIdx, vreg_idx_t'(r), '0, '0, fill);
      send_req(OpRedSum, '0, vreg_idx_t'(r), '0, '0);
    end
    for (int c = 0; c < 8; c++) begin
      op = opcode_t'(c);
      if (op != OpRedSum && op != OpExtract) begin
        send_req(op, vreg_idx_t'($random(seed)), vreg_idx_t'($random(seed)),
                 vreg_idx_t'($random(seed)), elem_t'($random(seed)));
      end
    end
    check_regs();
    end_test();

    start_test("back_pressure");
    for (int n = 0; n < 8; n++) begin
      hold = 1 + int'({$random(seed)} % 10);
      drive_req(OpRedSum, '0, vreg_idx_t'($random(seed)), '0, '0);
      finish_req(hold);
    end
    check_regs();
    end_test();

    if (exp_q.size() != 0) begin
      report_error("some responses never arrived");
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", nr_tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : vec_unit_tb

/* tb/vec_unit_asserts.sv */
// Handshake checks on the host ports of vec_unit
// All checks are off while reset is high

`timescale 1ns/1ps

module vec_unit_asserts (
  input logic           clk_i,
  input logic           reset_i,
  input logic           acc_req_valid_i,
  input logic           acc_req_ready_o,
  input logic           acc_resp_valid_o,
  input logic           acc_resp_ready_i,
  input vec_pkg::elem_t acc_resp_result_o
);

  // Set from acceptance until the response is taken
  logic pending_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (acc_req_valid_i && acc_req_ready_o) begin
      pending_q <= 1'b1;
    end else if (acc_resp_valid_o && acc_resp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  // Response holds until the host takes it
  resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_result_o))
    else $error("response changed while waiting for ready");

  // No new request until the pending response is taken
  ready_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
    pending_q |-> !acc_req_ready_o)
    else $error("request ready high with a pending response");

  // Sampled values lag one edge, so valid shows up on the fourth tick
  resp_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    acc_req_valid_i && acc_req_ready_o |-> ##4 $rose(acc_resp_valid_o))
    else $error("response valid did not rise 3 cycles after acceptance");

endmodule : vec_unit_asserts

bind vec_unit vec_unit_asserts i_vec_unit_asserts (
  .clk_i            (clk_i            ),
  .reset_i          (reset_i          ),
  .acc_req_valid_i  (acc_req_valid_i  ),
  .acc_req_ready_o  (acc_req_ready_o  ),
  .acc_resp_valid_o (acc_resp_valid_o ),
  .acc_resp_ready_i (acc_resp_ready_i ),
  .acc_resp_result_o(acc_resp_result_o)
);

/* src/vec_unit.sv */
// Vector unit top level, one instruction in flight at a time
// The response is valid exactly 3 cycles after the request is accepted

`timescale 1ns/1ps

module vec_unit (
  input  logic               clk_i,
  input  logic               reset_i,
  // Host request
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  input  vec_pkg::opcode_t   acc_req_op_i,
  input  vec_pkg::vreg_idx_t acc_req_vd_i,
  input  vec_pkg::vreg_idx_t acc_req_vs1_i,
  input  vec_pkg::vreg_idx_t acc_req_vs2_i,
  input  vec_pkg::elem_t     acc_req_scalar_i,
  // Host response
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  output vec_pkg::elem_t     acc_resp_result_o
);

  import vec_pkg::*;

  lane_issue_if issue_bus ();

  // Lane read-out towards the collector
  logic  [NrLanes-1:0]                   rd_valid;
  elem_t [NrLanes-1:0][ElemsPerLane-1:0] rd_elems;

  // Collector result back to the dispatcher
  logic  result_valid;
  elem_t result;

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i             (clk_i            ),
    .reset_i           (reset_i          ),
    .acc_req_valid_i   (acc_req_valid_i  ),
    .acc_req_ready_o   (acc_req_ready_o  ),
    .acc_req_op_i      (acc_req_op_i     ),
    .acc_req_vd_i      (acc_req_vd_i     ),
    .acc_req_vs1_i     (acc_req_vs1_i    ),
    .acc_req_vs2_i     (acc_req_vs2_i    ),
    .acc_req_scalar_i  (acc_req_scalar_i ),
    .acc_resp_valid_o  (acc_resp_valid_o ),
    .acc_resp_ready_i  (acc_resp_ready_i ),
    .acc_resp_result_o (acc_resp_result_o),
    .issue             (issue_bus        ),
    .result_valid_i    (result_valid     ),
    .result_i          (result           )
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  for (genvar g = 0; g < NrLanes; g++) begin : gen_lanes
    vec_lane #(
      .LaneId(lane_id_t'(g))
    ) i_lane (
      .clk_i     (clk_i      ),
      .reset_i   (reset_i    ),
      .issue     (issue_bus  ),
      .rd_valid_o(rd_valid[g]),
      .rd_elems_o(rd_elems[g])
    );
  end : gen_lanes

  //////////////////////////////
  // Collector
  //////////////////////////////

  vec_collector i_collector (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .issue         (issue_bus   ),
    .rd_valid_i    (rd_valid    ),
    .rd_elems_i    (rd_elems    ),
    .result_valid_o(result_valid),
    .result_o      (result      )
  );

endmodule : vec_unit

/* src/vec_collector.sv */
// Builds the scalar result from the lane read-out one cycle after the lanes
// Sum reduction wraps modulo 2**ElemWidth

`timescale 1ns/1ps

module vec_collector (
  input  logic                                                           clk_i,
  input  logic                                                           reset_i,
  lane_issue_if.collector                                                issue,
  input  logic [vec_pkg::NrLanes-1:0]                                    rd_valid_i,
  input  vec_pkg::elem_t [vec_pkg::NrLanes-1:0][vec_pkg::ElemsPerLane-1:0] rd_elems_i,
  output logic                                                           result_valid_o,
  output vec_pkg::elem_t                                                 result_o
);

  import vec_pkg::*;

  opcode_t   op_q;
  elem_idx_t idx_q;

  lane_id_t                        sel_lane;
  logic [$clog2(ElemsPerLane)-1:0] sel_slot;
  logic                            lanes_valid;
  elem_t                           result_d;

  // Lanes all answer in the same cycle
  assign lanes_valid = &rd_valid_i;

  // Extract index split into lane and slot
  assign sel_lane = idx_q[$bits(lane_id_t)-1:0];
  assign sel_slot = idx_q[$bits(elem_idx_t)-1:$bits(lane_id_t)];

  always_ff @(posedge clk_i) begin
    if (issue.valid) begin
      op_q  <= issue.op;
      idx_q <= elem_idx_t'(issue.scalar);
    end
  end

  always_comb begin
    elem_t sum;
    sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      for (int s = 0; s < ElemsPerLane; s++) begin
        sum = sum + rd_elems_i[l][s];
      end
    end
    case (op_q)
      OpRedSum:  result_d = sum;
      OpExtract: result_d = rd_elems_i[sel_lane][sel_slot];
      default:   result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= lanes_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lanes_valid) begin
      result_o <= result_d;
    end
  end

endmodule : vec_collector

/* dispatcher/vec_dispatcher.sv */
// Host handshake and instruction broadcast
// Opcodes pass through undecoded
// A new request is only taken once the previous response has been consumed

`timescale 1ns/1ps

module vec_dispatcher (
  input  logic               clk_i,
  input  logic               reset_i,
  // Host request
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  input  vec_pkg::opcode_t   acc_req_op_i,
  input  vec_pkg::vreg_idx_t acc_req_vd_i,
  input  vec_pkg::vreg_idx_t acc_req_vs1_i,
  input  vec_pkg::vreg_idx_t acc_req_vs2_i,
  input  vec_pkg::elem_t     acc_req_scalar_i,
  // Host response
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  output vec_pkg::elem_t     acc_resp_result_o,
  // Broadcast to lanes and collector
  lane_issue_if.dispatcher   issue,
  // Scalar result from the collector
  input  logic               result_valid_i,
  input  vec_pkg::elem_t     result_i
);

  import vec_pkg::*;

  disp_state_e state_q;
  disp_state_e state_d;

  // Captured instruction
  opcode_t   op_q;
  vreg_idx_t vd_q;
  vreg_idx_t vs1_q;
  vreg_idx_t vs2_q;
  elem_t     scalar_q;

  elem_t     result_q;
  logic      req_fire;

  assign acc_req_ready_o = (state_q == disp_idle);
  assign req_fire        = acc_req_valid_i && acc_req_ready_o;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      disp_idle:        if (req_fire) state_d = disp_issue;
      disp_issue:       state_d = disp_wait_result;
      disp_wait_result: if (result_valid_i) state_d = disp_respond;
      disp_respond:     if (acc_resp_ready_i) state_d = disp_idle;
      default:          state_d = disp_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= disp_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Captured request and collector result
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q     <= acc_req_op_i;
      vd_q     <= acc_req_vd_i;
      vs1_q    <= acc_req_vs1_i;
      vs2_q    <= acc_req_vs2_i;
      scalar_q <= acc_req_scalar_i;
    end
    if (state_q == disp_wait_result && result_valid_i) begin
      result_q <= result_i;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // One-cycle strobe in the cycle after acceptance
  assign issue.valid  = (state_q == disp_issue);
  assign issue.op     = op_q;
  assign issue.vd     = vd_q;
  assign issue.vs1    = vs1_q;
  assign issue.vs2    = vs2_q;
  assign issue.scalar = scalar_q;

  // Held steady until the host takes it
  assign acc_resp_valid_o  = (state_q == disp_respond);
  assign acc_resp_result_o = result_q;

endmodule : vec_dispatcher

/* lane/vec_lane.sv */
// One lane with its slice of every vector register and an element-wise ALU
// Registers are read before they are written on the same edge

`timescale 1ns/1ps

module vec_lane #(
  parameter vec_pkg::lane_id_t LaneId = '0
) (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  lane_issue_if.lane                                     issue,
  output logic                                           rd_valid_o,
  output vec_pkg::elem_t [vec_pkg::ElemsPerLane-1:0]     rd_elems_o
);

  import vec_pkg::*;

  // Register slice, slot s holds global element s*NrLanes + LaneId
  elem_t [ElemsPerLane-1:0] vrf_q [NrVRegs];
  elem_t [ElemsPerLane-1:0] wdata;
  logic                     vrf_we;

  // Only fill and the element-wise codes write back
  assign vrf_we = issue.valid &&
                  (issue.op inside {OpFillIdx, OpAdd, OpSub, OpAnd, OpXor});

  //////////////////////////////
  // ALU
  //////////////////////////////

  always_comb begin
    elem_t     op_a;
    elem_t     op_b;
    elem_idx_t gidx;
    wdata = '0;
    for (int s = 0; s < ElemsPerLane; s++) begin
      op_a = vrf_q[issue.vs1][s];
      op_b = vrf_q[issue.vs2][s];
      gidx = elem_idx_t'(s * NrLanes + int'(LaneId));
      case (issue.op)
        OpFillIdx: wdata[s] = issue.scalar + elem_t'(gidx);
        OpAdd:     wdata[s] = op_a + op_b;
        OpSub:     wdata[s] = op_a - op_b;
        OpAnd:     wdata[s] = op_a & op_b;
        OpXor:     wdata[s] = op_a ^ op_b;
        default:   wdata[s] = '0;
      endcase
    end
  end

  //////////////////////////////
  // Register file
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        vrf_q[r] <= '0;
      end
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= issue.valid;
      if (vrf_we) begin
        vrf_q[issue.vd] <= wdata;
      end
    end
  end

  // Old vs1 contents go to the collector
  always_ff @(posedge clk_i) begin
    if (issue.valid) begin
      rd_elems_o <= vrf_q[issue.vs1];
    end
  end

endmodule : vec_lane

/* common/lane_issue_if.sv */
// Broadcast of one instruction to all lanes and the collector
// The valid strobe lasts one cycle and has no ready
// Every receiver must take it

`timescale 1ns/1ps

interface lane_issue_if;

  logic               valid;
  vec_pkg::opcode_t   op;
  vec_pkg::vreg_idx_t vd;
  vec_pkg::vreg_idx_t vs1;
  vec_pkg::vreg_idx_t vs2;
  vec_pkg::elem_t     scalar;

  modport dispatcher (
    output valid, op, vd, vs1, vs2, scalar
  );

  modport lane (
    input valid, op, vd, vs1, vs2, scalar
  );

  // Operands reach the collector from the lanes
  modport collector (
    input valid, op, scalar
  );

endinterface : lane_issue_if

/* common/vec_pkg.sv */
// Sizes are fixed here, and the RTL is only built for four lanes of two elements each
// All element arithmetic wraps modulo 2**ElemWidth

package vec_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 2;
  localparam int unsigned VecLen       = NrLanes * ElemsPerLane;
  localparam int unsigned NrVRegs      = 4;
  localparam int unsigned ElemWidth    = 16;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [ElemWidth-1:0]         elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]   vreg_idx_t;
  // Element i sits in lane i mod NrLanes, slot i div NrLanes
  typedef logic [$clog2(VecLen)-1:0]    elem_idx_t;
  typedef logic [$clog2(NrLanes)-1:0]   lane_id_t;
  typedef logic [2:0]                   opcode_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  localparam opcode_t OpFillIdx = 3'd0;
  localparam opcode_t OpAdd     = 3'd1;
  localparam opcode_t OpSub     = 3'd2;
  localparam opcode_t OpAnd     = 3'd3;
  localparam opcode_t OpXor     = 3'd4;
  localparam opcode_t OpRedSum  = 3'd5;
  localparam opcode_t OpExtract = 3'd6;
  // Code 7 is a no-op with a zero result

  // Dispatcher FSM
  typedef enum logic [1:0] {
    disp_idle,
    disp_issue,
    disp_wait_result,
    disp_respond
  } disp_state_e;

endpackage : vec_pkg
